// File: src.f
verilog/mcuPkg.sv
verilog/cpuSequencer.sv
verilog/cpuDatapath.sv
verilog/baudTimer.sv
verilog/uartTx.sv
verilog/mcuResources.sv
verilog/mcu.sv
test/mcuTb.sv

// File: test/mcuTb.sv
`timescale 1ns/1ps

module mcuTb import mcuPkg::*; ();

	localparam int TIMEOUT_CYCLES = 20000;
	localparam int START_LIMIT = 2000;
	localparam int ECHO_LIMIT = 100;
	localparam int QUIET_CYCLES = 400;
	localparam int RAND_SEED = 32'h2390;

	logic CLK = 1'b0;
	logic rstN;
	logic fetch;
	logic decode;
	logic execute;
	logic commit;
	logic [15:0] addrPin;
	intVec_t ints;
	logic [3:0] dipSw;
	byte_t leds;
	logic txd;

	int cycleCount = 0;

	mcu mcu_inst (
		.CLK(CLK),
		.rstN(rstN),
		.fetch(fetch),
		.decode(decode),
		.execute(execute),
		.commit(commit),
		.addrPin(addrPin),
		.ints(ints),
		.dipSw(dipSw),
		.leds(leds),
		.txd(txd)
	);

	always #20 CLK = ~CLK;

	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish.", cycleCount);
			abortRun();
		end
	end

	task automatic abortRun();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic checkEq(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			abortRun();
		end
	endtask

	// Samples each bit near its middle, LSB first.
	task automatic getUartByte(output byte_t data);
		int waited;
		int i;
		waited = 0;
		data = '0;
		while (txd !== 1'b0) begin
			@(negedge CLK);
			waited++;
			if (waited > START_LIMIT) begin
				$display("No UART start bit seen within %0d cycles.", START_LIMIT);
				abortRun();
			end
		end
		repeat (CLKS_PER_BIT / 2) @(negedge CLK);
		checkEq("txd start bit", txd, 1'b0);
		for (i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge CLK);
			data[i] = txd;
		end
		repeat (CLKS_PER_BIT) @(negedge CLK);
		checkEq("txd stop bit", txd, 1'b1);
	endtask

	task automatic waitLeds(input byte_t expected, input int limit);
		int waited;
		waited = 0;
		while (leds !== expected && waited < limit) begin
			@(negedge CLK);
			waited++;
		end
		checkEq("leds", leds, expected);
	endtask

	task automatic checkEcho(input logic [3:0] value);
		@(negedge CLK);
		dipSw = value;
		waitLeds({4'h0, value}, ECHO_LIMIT);
	endtask

	task automatic pulseInt(input int index);
		@(negedge CLK);
		ints[index] = 1'b1;
		repeat (2) @(negedge CLK);
		ints[index] = 1'b0;
	endtask

	task automatic testReset();
		int i;
		@(negedge CLK);
		checkEq("phase strobes in reset", {fetch, decode, execute, commit}, 4'b0000);
		checkEq("txd in reset", txd, 1'b1);
		checkEq("leds in reset", leds, 8'h00);
		@(negedge CLK);
		rstN = 1'b1;
		// Three full rounds of fetch, decode, execute, commit.
		for (i = 0; i < 12; i++) begin
			@(negedge CLK);
			checkEq("phase strobes", {fetch, decode, execute, commit}, 4'b1000 >> (i % 4));
			checkEq("addrPin[15:12]", addrPin[15:12], 4'h0);
			// Word 0 is passed over, so the fetches run from 001.
			if (i % 4 == 0) begin
				checkEq("addrPin in fetch", addrPin, 16'h0001 + 16'(i / 4));
			end
			// Round 1 stores to the mask register.
			if (i == 6) begin
				checkEq("addrPin in store", addrPin, {4'h0, IO_INT_MASK});
			end
		end
	endtask

	task automatic testGreeting();
		byte_t rx;
		waitLeds(8'hA5, 200);
		getUartByte(rx);
		checkEq("UART byte", rx, 8'h4B);
	endtask

	task automatic testDipEcho();
		logic [3:0] value;
		logic [3:0] last;
		int n;
		last = dipSw;
		for (n = 0; n < 5; n++) begin
			value = 4'($urandom);
			// A repeat of the last value would pass without any echo.
			if (value == last) begin
				value = ~value;
			end
			checkEcho(value);
			last = value;
		end
	endtask

	task automatic testMaskedInt();
		pulseInt(1);
		repeat (QUIET_CYCLES) begin
			@(negedge CLK);
			checkEq("txd with int 1 masked", txd, 1'b1);
		end
		checkEcho(~dipSw);
	endtask

	task automatic testEnabledInt();
		byte_t rx;
		pulseInt(0);
		getUartByte(rx);
		checkEq("UART byte from ISR", rx, 8'h49);
		checkEcho(dipSw ^ 4'h5);
	endtask

	initial begin
		rstN = 1'b0;
		ints = '0;
		dipSw = 4'h0;
		void'($urandom(RAND_SEED));

		testReset();
		testGreeting();
		testDipEcho();
		testMaskedInt();
		testEnabledInt();

		$display("TEST OK");
		$finish;
	end

endmodule

// File: test/program.hex
// One 16-bit instruction per word, opcode in the top nibble and operand below.
// Words follow each other in address order from the last @ address.
@000
// Word 0 is passed over by the commit that leaves reset.
0000
// Enable interrupt 0, then LEDs = A5.
1001 3804 10A5 3800
// Wait for the UART, then send 4B.
2803 5008 4005 104B 3802
// Main loop at 00A, DIP switches to RAM, back, then to the LEDs.
2801 3400 2400 3800 400A
@010
// ISR saves acc, waits for the UART, sends 49.
3401 2803 5014 4011 1049 3802
// Clear pending bit 0, restore acc, return.
1001 3805 2401 6000

// File: verilog/baudTimer.sv
`timescale 1ns/1ps

module baudTimer import mcuPkg::*; (
	input  logic CLK,
	input  logic rstN,
	input  logic run,
	output logic tick
);

	baudCnt_t cnt;
	logic atEnd;

	assign atEnd = (cnt == baudCnt_t'(CLKS_PER_BIT - 1));
	assign tick = run && atEnd;

	// Held at zero while idle so each frame starts a full bit period.
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			cnt <= '0;
		end else if (!run || atEnd) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

// File: verilog/cpuDatapath.sv
`timescale 1ns/1ps

module cpuDatapath import mcuPkg::*; (
	input  logic CLK,
	input  logic rstN,
	input  phase_e phase,
	input  word_t rdata,
	input  logic irq,
	output busReq_t bus
);

	addr_t pc;
	addr_t pcNext;
	addr_t savedPc;
	word_t ir;
	word_t acc;
	logic inService;

	opcode_e opcode;
	addr_t operand;

	assign opcode = opcode_e'(ir[15:12]);
	assign operand = ir[11:0];

	// Bus request.
	always_comb begin
		bus = '0;
		bus.addr = pc;
		bus.wdata = acc;
		unique case (phase)
			PH_FETCH: begin
				bus.rd = 1'b1;
			end
			PH_EXECUTE: begin
				bus.addr = operand;
				bus.rd = (opcode == LD);
				bus.wr = (opcode == ST);
			end
			default: begin
			end
		endcase
	end

	// Next PC before any interrupt entry.
	always_comb begin
		pcNext = addr_t'(pc + 1'b1);
		case (opcode)
			JMP: pcNext = operand;
			JZ: begin
				if (acc == '0) begin
					pcNext = operand;
				end
			end
			RETI: pcNext = savedPc;
			default: begin
			end
		endcase
	end

	// Instruction register.
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			ir <= {NOP, 12'h000};
		end else if (phase == PH_DECODE) begin
			ir <= rdata;
		end
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			pc <= ROM_BASE;
			acc <= '0;
			savedPc <= '0;
			inService <= 1'b0;
		end else if (phase == PH_COMMIT) begin
			if (opcode == LD) begin
				acc <= rdata;
			end else if (opcode == LDI) begin
				acc <= word_t'(operand);
			end

			if (opcode == RETI) begin
				inService <= 1'b0;
			end

			// Interrupts are taken only between instructions, never nested.
			if (irq && !inService) begin
				savedPc <= pcNext;
				pc <= INT_VECTOR;
				inService <= 1'b1;
			end else begin
				pc <= pcNext;
			end
		end
	end

	busNoRdWr: assert property (
		@(posedge CLK) disable iff (!rstN)
		!(bus.rd && bus.wr)
	);

endmodule

// File: verilog/cpuSequencer.sv
`timescale 1ns/1ps

module cpuSequencer import mcuPkg::*; (
	input  logic CLK,
	input  logic rstN,
	output phase_e phase,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit
);

	phase_e phaseNext;

	always_comb begin
		unique case (phase)
			PH_FETCH: phaseNext = PH_DECODE;
			PH_DECODE: phaseNext = PH_EXECUTE;
			PH_EXECUTE: phaseNext = PH_COMMIT;
			default: phaseNext = PH_FETCH;
		endcase
	end

	// Parked in COMMIT so the first edge out of reset lands on FETCH.
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			phase <= PH_COMMIT;
		end else begin
			phase <= phaseNext;
		end
	end

	// Strobes track the phase register one for one.
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			fetch <= 1'b0;
			decode <= 1'b0;
			execute <= 1'b0;
			commit <= 1'b0;
		end else begin
			fetch <= (phaseNext == PH_FETCH);
			decode <= (phaseNext == PH_DECODE);
			execute <= (phaseNext == PH_EXECUTE);
			commit <= (phaseNext == PH_COMMIT);
		end
	end

	strobeOneHot: assert property (
		@(posedge CLK) disable iff (!rstN)
		$past(rstN) |-> $onehot({fetch, decode, execute, commit})
	);

endmodule

// File: verilog/mcu.sv
`timescale 1ns/1ps

module mcu import mcuPkg::*; (
	input  logic CLK,
	input  logic rstN,

	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit,

	output logic [15:0] addrPin,

	input  intVec_t ints,
	input  logic [3:0] dipSw,
	output byte_t leds,
	output logic txd
);

	phase_e phase;
	busReq_t bus;
	word_t rdata;
	logic irq;

	assign addrPin = {4'h0, bus.addr};

	cpuSequencer cpuSequencerInst (
		.CLK(CLK),
		.rstN(rstN),
		.phase(phase),
		.fetch(fetch),
		.decode(decode),
		.execute(execute),
		.commit(commit)
	);

	cpuDatapath cpuDatapathInst (
		.CLK(CLK),
		.rstN(rstN),
		.phase(phase),
		.rdata(rdata),
		.irq(irq),
		.bus(bus)
	);

	mcuResources mcuResourcesInst (
		.CLK(CLK),
		.rstN(rstN),
		.bus(bus),
		.rdata(rdata),
		.irq(irq),
		.ints(ints),
		.dipSw(dipSw),
		.leds(leds),
		.txd(txd)
	);

endmodule

// File: verilog/mcuPkg.sv
package mcuPkg;

	// Data and address widths.
	typedef logic [15:0] word_t;
	typedef logic [11:0] addr_t;
	typedef logic [7:0] byte_t;

	localparam int MEM_IDX_W = 8;
	typedef logic [MEM_IDX_W-1:0] memIdx_t;

	localparam int NUM_INTS = 2;
	typedef logic [NUM_INTS-1:0] intVec_t;

	// Instruction word is opcode[15:12], operand[11:0].
	typedef enum logic [3:0] {
		NOP  = 4'h0,
		LDI  = 4'h1,
		LD   = 4'h2,
		ST   = 4'h3,
		JMP  = 4'h4,
		JZ   = 4'h5,
		RETI = 4'h6
	} opcode_e;

	typedef enum logic [1:0] {
		PH_FETCH,
		PH_DECODE,
		PH_EXECUTE,
		PH_COMMIT
	} phase_e;

	typedef struct packed {
		addr_t addr;
		word_t wdata;
		logic rd;
		logic wr;
	} busReq_t;

	// Memory map.
	localparam addr_t ROM_BASE = 12'h000;
	localparam addr_t ROM_WORDS = 12'd256;
	localparam addr_t RAM_BASE = 12'h400;
	localparam addr_t RAM_WORDS = 12'd256;
	localparam addr_t IO_LED = 12'h800;
	localparam addr_t IO_DIPSW = 12'h801;
	localparam addr_t IO_UART_DATA = 12'h802;
	localparam addr_t IO_UART_STAT = 12'h803;
	localparam addr_t IO_INT_MASK = 12'h804;
	localparam addr_t IO_INT_PEND = 12'h805;
	localparam addr_t INT_VECTOR = 12'h010;

	// UART timing, 8N1.
	localparam int CLKS_PER_BIT = 8;
	localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT);
	typedef logic [BAUD_CNT_W-1:0] baudCnt_t;
	localparam int FRAME_BITS = 10;

	localparam string ROM_FILE = "test/program.hex";

endpackage

// File: verilog/mcuResources.sv
`timescale 1ns/1ps

module mcuResources import mcuPkg::*; (
	input  logic CLK,
	input  logic rstN,
	input  busReq_t bus,
	output word_t rdata,
	output logic irq,
	input  intVec_t ints,
	input  logic [3:0] dipSw,
	output byte_t leds,
	output logic txd
);

	word_t rom [ROM_WORDS];
	word_t ram [RAM_WORDS];

	memIdx_t romIdx;
	memIdx_t ramIdx;
	logic romHit;
	logic ramHit;
	word_t ioRdata;

	intVec_t mask;
	intVec_t pend;
	intVec_t intSync1;
	intVec_t intSync2;
	intVec_t intPrev;
	intVec_t intRise;
	intVec_t pendClr;

	logic uartLoad;
	logic uartBusy;

	initial begin
		$readmemh(ROM_FILE, rom);
	end

	// Address decode.
	assign romHit = (bus.addr >= ROM_BASE) && (bus.addr < ROM_BASE + ROM_WORDS);
	assign ramHit = (bus.addr >= RAM_BASE) && (bus.addr < RAM_BASE + RAM_WORDS);
	assign romIdx = memIdx_t'(bus.addr - ROM_BASE);
	assign ramIdx = memIdx_t'(bus.addr - RAM_BASE);

	assign uartLoad = bus.wr && (bus.addr == IO_UART_DATA);
	assign pendClr = (bus.wr && (bus.addr == IO_INT_PEND)) ? intVec_t'(bus.wdata) : '0;

	always_comb begin
		case (bus.addr)
			IO_LED: ioRdata = word_t'(leds);
			IO_DIPSW: ioRdata = word_t'(dipSw);
			IO_UART_STAT: ioRdata = word_t'(uartBusy);
			IO_INT_MASK: ioRdata = word_t'(mask);
			IO_INT_PEND: ioRdata = word_t'(pend);
			default: ioRdata = '0;
		endcase
	end

	// Read data is available the cycle after rd.
	always_ff @(posedge CLK) begin
		if (bus.rd) begin
			if (romHit) begin
				rdata <= rom[romIdx];
			end else if (ramHit) begin
				rdata <= ram[ramIdx];
			end else begin
				rdata <= ioRdata;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (bus.wr && ramHit) begin
			ram[ramIdx] <= bus.wdata;
		end
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			leds <= '0;
			mask <= '0;
		end else if (bus.wr) begin
			if (bus.addr == IO_LED) begin
				leds <= byte_t'(bus.wdata);
			end
			if (bus.addr == IO_INT_MASK) begin
				mask <= intVec_t'(bus.wdata);
			end
		end
	end

	// Two-flop synchronizer, then rising-edge detect.
	assign intRise = intSync2 & ~intPrev;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			intSync1 <= '0;
			intSync2 <= '0;
			intPrev <= '0;
			pend <= '0;
		end else begin
			intSync1 <= ints;
			intSync2 <= intSync1;
			intPrev <= intSync2;
			// A new edge wins over a clear in the same cycle.
			pend <= (pend & ~pendClr) | intRise;
		end
	end

	assign irq = |(pend & mask);

	uartTx uartTxInst (
		.CLK(CLK),
		.rstN(rstN),
		.load(uartLoad),
		.data(byte_t'(bus.wdata)),
		.busy(uartBusy),
		.txd(txd)
	);

endmodule

// File: verilog/uartTx.sv
`timescale 1ns/1ps

module uartTx import mcuPkg::*; (
	input  logic CLK,
	input  logic rstN,
	input  logic load,
	input  byte_t data,
	output logic busy,
	output logic txd
);

	logic [FRAME_BITS-1:0] shiftReg;
	logic [3:0] bitCnt;
	logic tick;

	baudTimer baudTimerInst (
		.CLK(CLK),
		.rstN(rstN),
		.run(busy),
		.tick(tick)
	);

	// Line is the low bit; ones shift in behind the frame.
	assign txd = shiftReg[0];

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			shiftReg <= '1;
			bitCnt <= '0;
			busy <= 1'b0;
		end else if (!busy) begin
			if (load) begin
				shiftReg <= {1'b1, data, 1'b0};
				bitCnt <= '0;
				busy <= 1'b1;
			end
		end else if (tick) begin
			shiftReg <= {1'b1, shiftReg[FRAME_BITS-1:1]};
			bitCnt <= bitCnt + 1'b1;
			// End of stop bit.
			if (bitCnt == 4'(FRAME_BITS - 1)) begin
				busy <= 1'b0;
			end
		end
	end

	idleLineHigh: assert property (
		@(posedge CLK) disable iff (!rstN)
		!busy |-> txd
	);

endmodule
